// File: bus_sub_unit.sv
// Bus master for one outstanding instruction read with a held response
`default_nettype none

module bus_sub_unit (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        req,
    input  wire logic [31:0] addr,
    input  wire logic        ack,
    output logic             ready,
    output logic             data_valid,
    output logic      [31:0] data,
    output logic             bus_req_valid,
    input  wire logic        bus_req_ready,
    output logic      [31:0] bus_addr,
    input  wire logic        bus_resp_valid,
    input  wire logic [31:0] bus_resp_data
);

    // Requesting phase is bus_req_valid, waiting phase is waiting
    logic waiting;

    always_ff @(posedge clk) begin
        if (req) begin
            bus_addr <= addr;
        end
        if (waiting && bus_resp_valid) begin
            data <= bus_resp_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_req_valid <= 1'b0;
            waiting <= 1'b0;
            data_valid <= 1'b0;
        end else begin
            if (req) begin
                bus_req_valid <= 1'b1;
            end else if (bus_req_valid && bus_req_ready) begin
                bus_req_valid <= 1'b0;
                waiting <= 1'b1;
            end
            if (waiting && bus_resp_valid) begin
                waiting <= 1'b0;
                data_valid <= 1'b1;
            end else if (ack) begin
                data_valid <= 1'b0;
            end
        end
    end

    assign ready = !bus_req_valid && !waiting && !data_valid;

endmodule

`default_nettype wire

// File: compile.f
fetch_cfg_pkg.sv
fetch_types_pkg.sv
imem_sub_unit.sv
bus_sub_unit.sv
fetch_tracker.sv
fetch_ctrl.sv
fetch_return_queue.sv
fetch_unit.sv
tb_clock_gen.sv
fetch_properties.sv
tb_fetch_unit.sv

// File: fetch_cfg_pkg.sv
// Fetch configuration with the memory map, reset vector and queue depth
`default_nettype none

package fetch_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // Memory map

    // First fetch after reset
    localparam logic [31:0] RESET_VEC = 32'h0000_0000;

    // Internal instruction memory
    localparam logic [31:0] IMEM_BASE = 32'h0000_0000;
    localparam int IMEM_WORDS = 16;
    localparam int IMEM_AW = $clog2(IMEM_WORDS);

    // External bus window
    localparam logic [31:0] BUS_BASE = 32'h0001_0000;
    localparam logic [31:0] BUS_BYTES = 32'h0000_1000;

    //////////////////////////////////////////////////////////////////////
    // Outstanding fetches

    localparam int FETCH_DEPTH = 2;
    // Counts 0 to FETCH_DEPTH inclusive
    localparam int FETCH_CW = $clog2(FETCH_DEPTH + 1);

endpackage

`default_nettype wire

// File: fetch_ctrl.sv
// Fetch control FSM holding the PC, choosing the next PC and issuing requests
`default_nettype none

module fetch_ctrl import fetch_cfg_pkg::*, fetch_types_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        flush,
    input  wire logic [31:0] flush_pc,
    input  wire logic        predict_taken,
    input  wire logic [31:0] predict_pc,
    input  wire logic        early_flush,
    input  wire logic [31:0] early_pc,
    input  wire logic        full,
    input  wire logic        imem_ready,
    input  wire logic        bus_ready,
    output logic      [31:0] fetch_pc,
    output logic             issue,
    output src_e             issue_src,
    output logic      [31:0] issue_pc,
    output logic             issue_predicted
);

    // INIT is !started, RUN is started && !halted, HALT is started && halted
    logic        started;
    logic        halted;
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic        unit_ready;
    logic        any_flush;

    assign any_flush = flush || early_flush;

    //////////////////////////////////////////////////////////////////////
    // Address decode

    always_comb begin
        if ((pc - IMEM_BASE) < 32'(IMEM_WORDS * 4)) begin
            issue_src = SRC_IMEM;
        end else if ((pc - BUS_BASE) < BUS_BYTES) begin
            issue_src = SRC_BUS;
        end else begin
            issue_src = SRC_NONE;
        end
    end

    // A fault entry needs no source
    always_comb begin
        case (issue_src)
            SRC_IMEM: unit_ready = imem_ready;
            SRC_BUS:  unit_ready = bus_ready;
            default:  unit_ready = 1'b1;
        endcase
    end

    assign issue = started && !halted && !full && unit_ready && !any_flush;
    assign issue_pc = pc;
    assign issue_predicted = predict_taken;
    assign fetch_pc = pc;

    //////////////////////////////////////////////////////////////////////
    // Next PC by priority with external flush first

    always_comb begin
        if (flush) begin
            next_pc = flush_pc;
        end else if (early_flush) begin
            next_pc = early_pc;
        end else if (predict_taken) begin
            next_pc = predict_pc;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
            halted <= 1'b0;
            pc <= RESET_VEC;
        end else begin
            if (!started) begin
                started <= 1'b1;
                pc <= RESET_VEC;
            end
            if (issue || any_flush) begin
                pc <= {next_pc[31:2], 2'b00};
            end
            // Stop after a fault entry until redirected
            if (any_flush) begin
                halted <= 1'b0;
            end else if (issue && (issue_src == SRC_NONE)) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: fetch_properties.sv
// Concurrent checks on the decode and bus handshakes of the fetch unit
`default_nettype none

module fetch_properties import fetch_types_pkg::*; (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic        flush,
    input wire logic        instr_valid,
    input wire logic        instr_ready,
    input wire instr_u      instr,
    input wire logic [31:0] instr_pc,
    input wire logic        instr_fault,
    input wire logic        bus_req_valid,
    input wire logic        bus_req_ready,
    input wire logic [31:0] bus_addr
);
    timeunit 1ns;
    timeprecision 100ps;

    // Number of assertion failures so far
    int fail_count = 0;

    // Held decode entry stays put unless a flush removes it
    a_instr_held: assert property (@(posedge clk) disable iff (rst)
        instr_valid && !instr_ready |=> flush || (instr_valid && $stable(instr)
            && $stable(instr_pc) && $stable(instr_fault)))
        else begin
            $error("decode output changed before it was accepted");
            fail_count++;
        end

    a_no_valid_in_flush: assert property (@(posedge clk) disable iff (rst)
        flush |-> !instr_valid)
        else begin
            $error("instr_valid high during an external flush");
            fail_count++;
        end

    a_fault_zero: assert property (@(posedge clk) disable iff (rst)
        instr_valid && instr_fault |-> instr.raw == 32'd0)
        else begin
            $error("fault entry carries a nonzero instruction");
            fail_count++;
        end

    a_bus_req_held: assert property (@(posedge clk) disable iff (rst)
        bus_req_valid && !bus_req_ready |=> bus_req_valid && $stable(bus_addr))
        else begin
            $error("bus request dropped or changed before bus_req_ready");
            fail_count++;
        end

endmodule

bind fetch_unit fetch_properties u_fetch_properties (
    .clk, .rst, .flush, .instr_valid, .instr_ready, .instr, .instr_pc,
    .instr_fault, .bus_req_valid, .bus_req_ready, .bus_addr
);

`default_nettype wire

// File: fetch_return_queue.sv
// Attribute queue matching responses to requests and driving the decode side
`default_nettype none

module fetch_return_queue import fetch_cfg_pkg::*, fetch_types_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        issue,
    input  wire src_e        issue_src,
    input  wire logic [31:0] issue_pc,
    input  wire logic        issue_predicted,
    input  wire logic        empty,
    input  wire logic        discard,
    input  wire logic        flush,
    input  wire logic        instr_ready,
    input  wire logic        imem_valid,
    input  wire logic [31:0] imem_data,
    input  wire logic        bus_valid,
    input  wire logic [31:0] bus_data,
    output logic             pop,
    output logic             imem_ack,
    output logic             bus_ack,
    output logic             early_flush,
    output logic      [31:0] early_pc,
    output logic             instr_valid,
    output instr_u           instr,
    output logic      [31:0] instr_pc,
    output logic             instr_fault
);

    fetch_attr_t                      attr_q [FETCH_DEPTH];
    logic [$clog2(FETCH_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(FETCH_DEPTH)-1:0]   rd_ptr;
    fetch_attr_t                      head;
    logic                             head_ready;
    logic                             accept;
    logic                             is_branch_or_jump;

    always_ff @(posedge clk) begin
        if (issue) begin
            attr_q[wr_ptr] <= '{pc: issue_pc, src: issue_src, predicted: issue_predicted};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            wr_ptr <= wr_ptr + issue;
            rd_ptr <= rd_ptr + pop;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Head response selection

    assign head = attr_q[rd_ptr];

    always_comb begin
        case (head.src)
            SRC_IMEM: begin
                head_ready = imem_valid;
                instr.raw = imem_data;
            end
            SRC_BUS: begin
                head_ready = bus_valid;
                instr.raw = bus_data;
            end
            default: begin
                // Fault entry is ready at once
                head_ready = 1'b1;
                instr.raw = '0;
            end
        endcase
    end

    assign instr_pc = head.pc;
    assign instr_fault = (head.src == SRC_NONE);
    assign instr_valid = !empty && head_ready && !discard && !flush;
    assign accept = instr_valid && instr_ready;

    // Stale heads drain without reaching decode
    assign pop = !empty && head_ready && !flush && (discard || instr_ready);
    assign imem_ack = pop && (head.src == SRC_IMEM);
    assign bus_ack = pop && (head.src == SRC_BUS);

    //////////////////////////////////////////////////////////////////////
    // Early branch check

    assign is_branch_or_jump = instr.f.opcode inside {OPC_BRANCH, OPC_JAL, OPC_JALR};
    assign early_flush = accept && head.predicted && !instr_fault && !is_branch_or_jump;
    assign early_pc = head.pc + 32'd4;

endmodule

`default_nettype wire

// File: fetch_tracker.sv
// Counters for requests in flight and stale responses to discard after a flush
`default_nettype none

module fetch_tracker import fetch_cfg_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic issue,
    input  wire logic pop,
    input  wire logic flush,
    input  wire logic early_flush,
    output logic      full,
    output logic      empty,
    output logic      discard
);

    logic [FETCH_CW-1:0] inflight;
    logic [FETCH_CW-1:0] inflight_next;
    logic [FETCH_CW-1:0] discard_cnt;

    assign inflight_next = inflight + FETCH_CW'(issue) - FETCH_CW'(pop);

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight <= '0;
            discard_cnt <= '0;
        end else begin
            inflight <= inflight_next;
            // Everything still outstanding after a redirect is stale
            if (flush || early_flush) begin
                discard_cnt <= inflight_next;
            end else if (discard && pop) begin
                discard_cnt <= discard_cnt - 1'b1;
            end
        end
    end

    assign full = (inflight == FETCH_CW'(FETCH_DEPTH));
    assign empty = (inflight == '0);
    assign discard = (discard_cnt != '0);

endmodule

`default_nettype wire

// File: fetch_types_pkg.sv
// Instruction encoding and per-request fetch attribute types
`default_nettype none

package fetch_types_pkg;

    //////////////////////////////////////////////////////////////////////
    // Instruction word

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_fields_t;

    // Raw word for decode, field view for the early branch check
    typedef union packed {
        logic [31:0]   raw;
        instr_fields_t f;
    } instr_u;

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    //////////////////////////////////////////////////////////////////////
    // Fetch attributes

    // SRC_NONE marks an address outside both windows
    typedef enum logic [1:0] {
        SRC_IMEM = 2'd0,
        SRC_BUS  = 2'd1,
        SRC_NONE = 2'd2
    } src_e;

    typedef struct packed {
        logic [31:0] pc;
        src_e        src;
        logic        predicted;
    } fetch_attr_t;

endpackage

`default_nettype wire

// File: fetch_unit.sv
// Instruction fetch unit top level joining control, tracking, queue and sources
`default_nettype none

module fetch_unit import fetch_types_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        flush,
    input  wire logic [31:0] flush_pc,
    input  wire logic        predict_taken,
    input  wire logic [31:0] predict_pc,
    output logic      [31:0] fetch_pc,
    output logic             instr_valid,
    input  wire logic        instr_ready,
    output instr_u           instr,
    output logic      [31:0] instr_pc,
    output logic             instr_fault,
    output logic             bus_req_valid,
    input  wire logic        bus_req_ready,
    output logic      [31:0] bus_addr,
    input  wire logic        bus_resp_valid,
    input  wire logic [31:0] bus_resp_data
);

    logic        issue;
    src_e        issue_src;
    logic [31:0] issue_pc;
    logic        issue_predicted;
    logic        early_flush;
    logic [31:0] early_pc;
    logic        full;
    logic        empty;
    logic        discard;
    logic        pop;

    logic        imem_req;
    logic        imem_ready;
    logic        imem_valid;
    logic [31:0] imem_data;
    logic        imem_ack;
    logic        bus_req;
    logic        bus_ready;
    logic        bus_valid;
    logic [31:0] bus_data;
    logic        bus_ack;

    // Steer the issue pulse to the addressed source
    assign imem_req = issue && (issue_src == SRC_IMEM);
    assign bus_req  = issue && (issue_src == SRC_BUS);

    fetch_ctrl u_fetch_ctrl (
        .clk, .rst, .flush, .flush_pc, .predict_taken, .predict_pc,
        .early_flush, .early_pc, .full, .imem_ready, .bus_ready,
        .fetch_pc, .issue, .issue_src, .issue_pc, .issue_predicted
    );

    fetch_tracker u_fetch_tracker (
        .clk, .rst, .issue, .pop, .flush, .early_flush, .full, .empty, .discard
    );

    fetch_return_queue u_fetch_return_queue (
        .clk, .rst, .issue, .issue_src, .issue_pc, .issue_predicted,
        .empty, .discard, .flush, .instr_ready,
        .imem_valid, .imem_data, .bus_valid, .bus_data,
        .pop, .imem_ack, .bus_ack, .early_flush, .early_pc,
        .instr_valid, .instr, .instr_pc, .instr_fault
    );

    imem_sub_unit u_imem_sub_unit (
        .clk, .rst, .req(imem_req), .addr(issue_pc), .ack(imem_ack),
        .ready(imem_ready), .data_valid(imem_valid), .data(imem_data)
    );

    bus_sub_unit u_bus_sub_unit (
        .clk, .rst, .req(bus_req), .addr(issue_pc), .ack(bus_ack),
        .ready(bus_ready), .data_valid(bus_valid), .data(bus_data),
        .bus_req_valid, .bus_req_ready, .bus_addr, .bus_resp_valid, .bus_resp_data
    );

endmodule

`default_nettype wire

// File: imem.hex
// One 32-bit instruction word per line, word 0 at address 0
// Word 5 is a JAL and word 9 a BEQ, all others are ADDI
00100093
00200113
00300193
00400213
00500293
0100006f
00600313
00700393
00800413
fe0008e3
00900493
00a00513
00b00593
00c00613
00d00693
00e00713

// File: imem_sub_unit.sv
// Internal instruction memory with one-cycle read and a held response
`default_nettype none

module imem_sub_unit import fetch_cfg_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        req,
    input  wire logic [31:0] addr,
    input  wire logic        ack,
    output logic             ready,
    output logic             data_valid,
    output logic      [31:0] data
);

    logic [31:0]        mem [IMEM_WORDS];
    logic [31:0]        offset;
    logic [IMEM_AW-1:0] index;

    initial begin
        $readmemh("imem.hex", mem);
    end

    // Word index within the memory window
    assign offset = addr - IMEM_BASE;
    assign index = offset[IMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (req) begin
            data <= mem[index];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_valid <= 1'b0;
        end else if (req) begin
            data_valid <= 1'b1;
        end else if (ack) begin
            data_valid <= 1'b0;
        end
    end

    // No new read while a word waits for its ack
    assign ready = !data_valid;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch unit simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_fetch_unit \
    -f compile.f

out=$(./obj_dir/Vtb_fetch_unit)
echo "$out"

if grep -qF '*** PASSED ***' <<< "$out"; then
    exit 0
else
    exit 1
fi

// File: tb_clock_gen.sv
// Testbench clock with an 8 ns period and a 10-cycle reset
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb_fetch_unit.sv
// Table-driven testbench for the fetch unit with bus model and reference stream
`default_nettype none

module tb_fetch_unit import fetch_cfg_pkg::*, fetch_types_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROWS = 6;
    localparam int NPRED = 3;

    logic        clk;
    logic        rst;
    logic        flush;
    logic [31:0] flush_pc;
    logic        predict_taken;
    logic [31:0] predict_pc;
    logic [31:0] fetch_pc;
    logic        instr_valid;
    logic        instr_ready;
    instr_u      instr;
    logic [31:0] instr_pc;
    logic        instr_fault;
    logic        bus_req_valid;
    logic        bus_req_ready;
    logic [31:0] bus_addr;
    logic        bus_resp_valid;
    logic [31:0] bus_resp_data;

    ////////////////////////////////////////////////////////////////////
    // Stimulus table of start pc and number of deliveries to check
    logic [31:0] row_pc [ROWS] = '{RESET_VEC, 32'h0001_0000, 32'h0000_0020,
                                  32'h0000_0030, 32'h0000_2000, 32'h0001_0100};
    int          row_count [ROWS] = '{11, 8, 4, 3, 1, 4};

    // Predicted-taken addresses and their targets
    logic [31:0] pred_addr [NPRED] = '{32'h14, 32'h24, 32'h30};
    logic [31:0] pred_tgt [NPRED] = '{32'h30, 32'h04, 32'h08};

    logic [31:0] ref_mem [IMEM_WORDS];
    logic [31:0] exp_pc [$];
    instr_u      exp_word [$];
    logic        exp_fault [$];

    integer      seed = 64;
    int          errors = 0;
    int          checked = 0;
    int          cycles = 0;
    int          limit = 0;
    logic        took;
    int          req_wait = -1;
    int          resp_wait = -1;
    logic [31:0] req_addr;

    tb_clock_gen u_clock_gen (.clk, .rst);

    fetch_unit u_fetch_unit (
        .clk, .rst, .flush, .flush_pc, .predict_taken, .predict_pc, .fetch_pc,
        .instr_valid, .instr_ready, .instr, .instr_pc, .instr_fault,
        .bus_req_valid, .bus_req_ready, .bus_addr, .bus_resp_valid, .bus_resp_data
    );

    function automatic int find_prediction(input logic [31:0] a);
        for (int i = 0; i < NPRED; i++) begin
            if (pred_addr[i] == a) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Bus words carry an ADDI opcode under the word address bits
    function automatic logic [31:0] bus_word(input logic [31:0] a);
        return {a[26:2], OPC_OP_IMM};
    endfunction

    // Reference stream for one row
    task automatic build_expected(input logic [31:0] start, input int count);
        logic [31:0] pc;
        instr_u      w;
        int          p;
        exp_pc.delete();
        exp_word.delete();
        exp_fault.delete();
        pc = start;
        while (exp_pc.size() < count) begin
            if ((pc - IMEM_BASE) < 32'(IMEM_WORDS * 4)) begin
                w.raw = ref_mem[(pc - IMEM_BASE) >> 2];
            end else if ((pc - BUS_BASE) < BUS_BYTES) begin
                w.raw = bus_word(pc);
            end else begin
                exp_pc.push_back(pc);
                exp_word.push_back('0);
                exp_fault.push_back(1'b1);
                break;
            end
            exp_pc.push_back(pc);
            exp_word.push_back(w);
            exp_fault.push_back(1'b0);
            p = find_prediction(pc);
            // Only a real branch or jump follows its prediction
            if (p >= 0 && (w.f.opcode inside {OPC_BRANCH, OPC_JAL, OPC_JALR})) begin
                pc = pred_tgt[p];
            end else begin
                pc = pc + 32'd4;
            end
        end
    endtask

    task automatic check_instr(input instr_u got, input instr_u exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: instr %h, expected %h", $time, got.raw, exp.raw);
        end
    endtask

    task automatic check_pc(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: instr_pc %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_fault(input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: instr_fault %b, expected %b", $time, got, exp);
        end
    endtask

    // One cycle of driving, then a look at the upcoming transfer
    task automatic step(input logic do_flush, input logic [31:0] fpc, input logic want);
        int p;
        @(negedge clk);
        flush = do_flush;
        flush_pc = fpc;
        instr_ready = want && (($unsigned($random(seed)) % 4) != 0);
        p = find_prediction(fetch_pc);
        predict_taken = (p >= 0);
        predict_pc = (p >= 0) ? pred_tgt[p] : 32'd0;
        #1;
        took = instr_valid && instr_ready;
    endtask

    ////////////////////////////////////////////////////////////////////
    // Bus model with random grant and response delays
    always @(negedge clk) begin
        bus_resp_valid = 1'b0;
        if (rst) begin
            req_wait = -1;
            resp_wait = -1;
            bus_req_ready = 1'b0;
        end else begin
            if (bus_req_ready) begin
                bus_req_ready = 1'b0;
                resp_wait = 1 + int'($unsigned($random(seed)) % 4);
            end else if (bus_req_valid && req_wait < 0) begin
                req_wait = int'($unsigned($random(seed)) % 4);
            end
            if (req_wait == 0) begin
                bus_req_ready = 1'b1;
                req_addr = bus_addr;
                req_wait = -1;
            end else if (req_wait > 0) begin
                req_wait--;
            end
            if (resp_wait > 0) begin
                resp_wait--;
                if (resp_wait == 0) begin
                    bus_resp_valid = 1'b1;
                    bus_resp_data = bus_word(req_addr);
                    resp_wait = -1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: run did not finish within %0d cycles", limit);
                $display("*** FAILED ***");
                $finish;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        int n;
        flush = 1'b0;
        flush_pc = '0;
        predict_taken = 1'b0;
        predict_pc = '0;
        instr_ready = 1'b0;
        bus_req_ready = 1'b0;
        bus_resp_valid = 1'b0;
        bus_resp_data = '0;
        $readmemh("imem.hex", ref_mem);
        for (int r = 0; r < ROWS; r++) begin
            limit += row_count[r] * 12;
        end
        limit += 200;
        wait (!rst);
        for (int r = 0; r < ROWS; r++) begin
            build_expected(row_pc[r], row_count[r]);
            if (r > 0) begin
                // Stall decode so requests are still in flight at the flush
                repeat (4) begin
                    step(1'b0, 32'd0, 1'b0);
                end
                step(1'b1, row_pc[r], 1'b0);
            end
            n = 0;
            while (n < exp_pc.size()) begin
                step(1'b0, 32'd0, 1'b1);
                if (took) begin
                    check_pc(instr_pc, exp_pc[n]);
                    check_instr(instr, exp_word[n]);
                    check_fault(instr_fault, exp_fault[n]);
                    checked++;
                    n++;
                end
            end
            // Fetch stays halted after a fault
            if (exp_fault[exp_fault.size() - 1]) begin
                repeat (20) begin
                    step(1'b0, 32'd0, 1'b1);
                    if (instr_valid) begin
                        errors++;
                        $display("An instruction was delivered after a fault at %0t", $time);
                    end
                end
            end
        end
        step(1'b0, 32'd0, 1'b0);
        errors += u_fetch_unit.u_fetch_properties.fail_count;
        $display("Run complete: %0d compared, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
